//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pi_ctrl
FILELIST  ?= pi_ctrl.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing -Wno-fatal -j $(JOBS)
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/phase_monitor.sv
`timescale 1ns/1ps

module phase_monitor (
    input  logic                              bld_out,
    input  logic                              rstb,
    input  logic                              upd,
    input  logic signed [pi_pkg::DELTA_W-1:0] delta,
    input  logic                              en_pm,
    input  pi_pkg::pm_sign_e                  pm_sign,
    output logic [pi_pkg::PM_W-1:0]           pm_out
);

    localparam int EXT_W = pi_pkg::PM_W - pi_pkg::DELTA_W;

    logic [pi_pkg::PM_W-1:0] delta_ext;

    assign delta_ext = {{EXT_W{delta[pi_pkg::DELTA_W-1]}}, delta};  // Sign extend.

    always_ff @(posedge bld_out or negedge rstb) begin
        if (!rstb) begin
            pm_out <= '0;
        end else if (upd && en_pm) begin
            case (pm_sign)
                pi_pkg::PM_ADD: pm_out <= pm_out + delta_ext;
                pi_pkg::PM_SUB: pm_out <= pm_out - delta_ext;
                default:        pm_out <= pm_out;  // Hold.
            endcase
        end
    end

endmodule

//--- hdl/pi_cfg_regs.sv
`timescale 1ns/1ps

module pi_cfg_regs (
    input  logic            bld_out,
    input  logic            rstb,
    input  logic            cfg_wr,
    input  pi_pkg::pi_cfg_t cfg_wdata,
    output pi_pkg::pi_cfg_t cfg
);

    pi_pkg::pm_sign_e sign_clean;

    // Only the three defined monitor modes get through.
    always_comb begin
        case (cfg_wdata.pm_sign)
            pi_pkg::PM_ADD: sign_clean = pi_pkg::PM_ADD;
            pi_pkg::PM_SUB: sign_clean = pi_pkg::PM_SUB;
            default:        sign_clean = pi_pkg::PM_HOLD;
        endcase
    end

    always_ff @(posedge bld_out or negedge rstb) begin
        if (!rstb) begin
            cfg.en_ext_qperi <= 1'b0;  // Arbiter count drives qperi.
            cfg.ext_qperi    <= '0;
            cfg.en_pm        <= 1'b0;
            cfg.pm_sign      <= pi_pkg::PM_HOLD;
        end else if (cfg_wr) begin
            cfg.en_ext_qperi <= cfg_wdata.en_ext_qperi;
            cfg.ext_qperi    <= cfg_wdata.ext_qperi;
            cfg.en_pm        <= cfg_wdata.en_pm;
            cfg.pm_sign      <= sign_clean;
        end
    end

endmodule

//--- hdl/pi_cmd_fifo.sv
`timescale 1ns/1ps

module pi_cmd_fifo #(
    parameter int CMD_DEPTH = 4
) (
    input  logic            bld_out,
    input  logic            rstb,
    input  logic            cmd_valid,
    input  pi_pkg::pi_cmd_t cmd,
    input  logic            pop,
    output pi_pkg::pi_cmd_t head,
    output logic            not_empty,
    output logic            credit
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    pi_pkg::pi_cmd_t mem [CMD_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    assign not_empty = (count != '0);
    assign do_pop    = pop & not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge bld_out) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge bld_out or negedge rstb) begin
        if (!rstb) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= do_pop;  // One credit back per pop.
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({cmd_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Push and pop cancel.
            endcase
        end
    end

endmodule

//--- hdl/pi_code_sequencer.sv
`timescale 1ns/1ps

module pi_code_sequencer #(
    parameter int NBLENDER = 4,
    parameter int NUNIT    = 32
) (
    input  logic                                    bld_out,
    input  logic                                    rstb,
    input  logic                                    freeze,
    input  logic                                    not_empty,
    input  pi_pkg::pi_cmd_t                         head,
    input  logic [$clog2(NUNIT)+NBLENDER:0]         code_range,
    output logic                                    pop,
    output logic [$clog2(NUNIT)+NBLENDER-1:0]       code,
    output logic                                    upd,
    output logic signed [pi_pkg::DELTA_W-1:0]       delta,
    output logic                                    cfg_wr,
    output pi_pkg::pi_cfg_t                         cfg_wdata
);

    localparam int CODE_W = $clog2(NUNIT) + NBLENDER;

    logic [CODE_W-1:0]                 last_code;
    logic [CODE_W-1:0]                 next_code;
    logic                              is_code_op;
    logic signed [pi_pkg::DELTA_W-1:0] delta_nxt;

    assign pop       = not_empty & ~freeze;  // Freeze holds the queue.
    assign last_code = CODE_W'(code_range - 1'b1);

    always_comb begin
        next_code  = code;
        is_code_op = 1'b1;
        case (head.op)
            pi_pkg::OP_SET_CODE: begin
                if (head.arg > pi_pkg::CMD_ARG_W'(last_code)) begin
                    next_code = last_code;  // Clamp to top.
                end else begin
                    next_code = CODE_W'(head.arg);
                end
            end
            pi_pkg::OP_STEP_UP: begin
                next_code = (code >= last_code) ? '0 : code + 1'b1;
            end
            pi_pkg::OP_STEP_DOWN: begin
                // Also pulls a stale code back after the range shrinks.
                if (code == '0 || code > last_code) begin
                    next_code = last_code;
                end else begin
                    next_code = code - 1'b1;
                end
            end
            default: is_code_op = 1'b0;
        endcase
    end

    // Zero extended, so the difference is exact in two's complement.
    assign delta_nxt = pi_pkg::DELTA_W'(next_code) - pi_pkg::DELTA_W'(code);

    assign cfg_wr    = pop && (head.op == pi_pkg::OP_WR_CFG);
    assign cfg_wdata = pi_pkg::pi_cfg_t'(head.arg[pi_pkg::CFG_W-1:0]);

    always_ff @(posedge bld_out or negedge rstb) begin
        if (!rstb) begin
            code <= '0;
            upd  <= 1'b0;
        end else begin
            upd <= pop & is_code_op;
            if (pop && is_code_op) begin
                code <= next_code;
            end
        end
    end

    always_ff @(posedge bld_out) begin
        if (pop && is_code_op) begin
            delta <= delta_nxt;  // Valid with upd.
        end
    end

endmodule

//--- hdl/pi_ctrl_top.sv
`timescale 1ns/1ps

module pi_ctrl_top #(
    parameter int NUNIT     = 32,
    parameter int NBLENDER  = 4,
    parameter int CMD_DEPTH = 4
) (
    input  logic                            bld_out,
    input  logic                            rstb,
    input  logic                            freeze,
    input  logic                            cmd_valid,
    input  pi_pkg::pi_cmd_t                 cmd,
    input  logic [NUNIT-1:0]                arb_out,
    output logic                            credit,
    output logic [$clog2(NUNIT+1)-1:0]      qperi,
    output logic [$clog2(NUNIT)-1:0]        max_sel_mux,
    output logic [$clog2(NUNIT)-1:0]        sel_lead,
    output logic [$clog2(NUNIT)-1:0]        sel_lag,
    output logic [NUNIT-1:0]                en_mixer,
    output logic [2**NBLENDER-1:0]          thm_sel_bld,
    output logic [pi_pkg::PM_W-1:0]         pm_out
);

    localparam int CODE_W = $clog2(NUNIT) + NBLENDER;

    pi_pkg::pi_cmd_t                   head;
    logic                              not_empty;
    logic                              pop;
    logic [CODE_W-1:0]                 code;
    logic [CODE_W:0]                   code_range;
    logic                              upd;
    logic signed [pi_pkg::DELTA_W-1:0] delta;
    logic                              cfg_wr;
    pi_pkg::pi_cfg_t                   cfg_wdata;
    pi_pkg::pi_cfg_t                   cfg;

    pi_cmd_fifo #(
        .CMD_DEPTH(CMD_DEPTH)
    ) u_cmd_fifo (
        .bld_out(bld_out),
        .rstb(rstb),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .pop(pop),
        .head(head),
        .not_empty(not_empty),
        .credit(credit)
    );

    pi_code_sequencer #(
        .NBLENDER(NBLENDER),
        .NUNIT(NUNIT)
    ) u_code_sequencer (
        .bld_out(bld_out),
        .rstb(rstb),
        .freeze(freeze),
        .not_empty(not_empty),
        .head(head),
        .code_range(code_range),
        .pop(pop),
        .code(code),
        .upd(upd),
        .delta(delta),
        .cfg_wr(cfg_wr),
        .cfg_wdata(cfg_wdata)
    );

    pi_cfg_regs u_cfg_regs (
        .bld_out(bld_out),
        .rstb(rstb),
        .cfg_wr(cfg_wr),
        .cfg_wdata(cfg_wdata),
        .cfg(cfg)
    );

    pi_local_encoder #(
        .NUNIT(NUNIT),
        .NBLENDER(NBLENDER)
    ) u_local_encoder (
        .bld_out(bld_out),
        .rstb(rstb),
        .code(code),
        .arb_out(arb_out),
        .en_ext_qperi(cfg.en_ext_qperi),
        .ext_qperi(cfg.ext_qperi),
        .qperi(qperi),
        .max_sel_mux(max_sel_mux),
        .code_range(code_range),
        .sel_lead(sel_lead),
        .sel_lag(sel_lag),
        .en_mixer(en_mixer),
        .thm_sel_bld(thm_sel_bld)
    );

    phase_monitor u_phase_monitor (
        .bld_out(bld_out),
        .rstb(rstb),
        .upd(upd),
        .delta(delta),
        .en_pm(cfg.en_pm),
        .pm_sign(cfg.pm_sign),
        .pm_out(pm_out)
    );

endmodule

//--- hdl/pi_local_encoder.sv
`timescale 1ns/1ps

module pi_local_encoder #(
    parameter int NUNIT    = 32,
    parameter int NBLENDER = 4
) (
    input  logic                                bld_out,
    input  logic                                rstb,
    input  logic [$clog2(NUNIT)+NBLENDER-1:0]   code,
    input  logic [NUNIT-1:0]                    arb_out,
    input  logic                                en_ext_qperi,
    input  logic [pi_pkg::EXT_Q_W-1:0]          ext_qperi,
    output logic [$clog2(NUNIT+1)-1:0]          qperi,
    output logic [$clog2(NUNIT)-1:0]            max_sel_mux,
    output logic [$clog2(NUNIT)+NBLENDER:0]     code_range,
    output logic [$clog2(NUNIT)-1:0]            sel_lead,
    output logic [$clog2(NUNIT)-1:0]            sel_lag,
    output logic [NUNIT-1:0]                    en_mixer,
    output logic [2**NBLENDER-1:0]              thm_sel_bld
);

    localparam int SEL_W = $clog2(NUNIT);
    localparam int CODE_W = SEL_W + NBLENDER;
    localparam int RW = CODE_W + 1;
    localparam int QW = $clog2(NUNIT + 1);
    localparam int NTHM = 2**NBLENDER;
    // Decode of code 0 with qperi 0, seen straight out of reset.
    localparam int P_RST = (NUNIT < 4) ? NUNIT : 4;
    localparam int LAG_RST = (P_RST > 1) ? 1 : 0;
    localparam logic [NUNIT-1:0] MIX_RST = (NUNIT'(1) << LAG_RST) | NUNIT'(1);

    logic [QW-1:0]       ones;
    logic [QW-1:0]       q_nxt;
    logic [QW-1:0]       q_eff;
    logic [QW+1:0]       four_q;
    logic [QW-1:0]       p_nxt;
    logic [SEL_W-1:0]    max_nxt;
    logic [RW-1:0]       range_nxt;
    logic [SEL_W-1:0]    coarse;
    logic [NBLENDER-1:0] fine;
    logic [SEL_W-1:0]    lag_nxt;
    logic [NUNIT-1:0]    mix_nxt;
    logic [NTHM-1:0]     thm_nxt;

    always_comb begin
        ones = '0;
        for (int i = 0; i < NUNIT; i++) begin
            ones = ones + QW'(arb_out[i]);  // Calibration ones count.
        end
    end

    always_comb begin
        if (!en_ext_qperi) begin
            q_nxt = ones;
        end else if (ext_qperi > NUNIT) begin
            q_nxt = QW'(NUNIT);  // Override saturates.
        end else begin
            q_nxt = QW'(ext_qperi);
        end
    end

    assign q_eff     = (q_nxt == '0) ? QW'(1) : q_nxt;
    assign four_q    = {q_eff, 2'b00};
    assign p_nxt     = (four_q > NUNIT) ? QW'(NUNIT) : QW'(four_q);
    assign max_nxt   = SEL_W'(p_nxt - 1'b1);
    assign range_nxt = RW'(p_nxt) << NBLENDER;

    assign coarse  = code[CODE_W-1:NBLENDER];
    assign fine    = code[NBLENDER-1:0];
    assign lag_nxt = (coarse >= max_nxt) ? '0 : coarse + 1'b1;
    assign thm_nxt = ~({NTHM{1'b1}} << fine);  // Lowest fine bits set.

    always_comb begin
        mix_nxt          = '0;
        mix_nxt[coarse]  = 1'b1;
        mix_nxt[lag_nxt] = 1'b1;
    end

    always_ff @(posedge bld_out or negedge rstb) begin
        if (!rstb) begin
            qperi       <= '0;
            max_sel_mux <= SEL_W'(P_RST - 1);
            code_range  <= RW'(P_RST * NTHM);
            sel_lead    <= '0;
            sel_lag     <= SEL_W'(LAG_RST);
            en_mixer    <= MIX_RST;
            thm_sel_bld <= '0;
        end else begin
            qperi       <= q_nxt;
            max_sel_mux <= max_nxt;
            code_range  <= range_nxt;
            sel_lead    <= coarse;
            sel_lag     <= lag_nxt;
            en_mixer    <= mix_nxt;
            thm_sel_bld <= thm_nxt;  // Sampled like the blender select.
        end
    end

endmodule

//--- hdl/pi_pkg.sv
package pi_pkg;

    // Command wire format.
    localparam int CMD_ARG_W = 16;
    localparam int OP_W = 2;

    // Configuration fields.
    localparam int EXT_Q_W = 8;
    localparam int CFG_W = 12;

    // Code movement is carried one bit wider than any argument.
    localparam int DELTA_W = CMD_ARG_W + 1;

    // Phase monitor accumulator.
    localparam int PM_W = 20;

    typedef enum logic [OP_W-1:0] {
        OP_SET_CODE  = 2'd0,  // Load code, clamped.
        OP_STEP_UP   = 2'd1,  // Code plus one, wrapping.
        OP_STEP_DOWN = 2'd2,  // Code minus one, wrapping.
        OP_WR_CFG    = 2'd3   // Low CFG_W bits of arg to cfg.
    } pi_op_e;

    typedef enum logic [1:0] {
        PM_HOLD = 2'd0,
        PM_ADD  = 2'd1,
        PM_SUB  = 2'd2
    } pm_sign_e;

    typedef struct packed {
        pi_op_e               op;
        logic [CMD_ARG_W-1:0] arg;
    } pi_cmd_t;

    // Bit order matches arg[CFG_W-1:0] of a write command.
    typedef struct packed {
        logic               en_ext_qperi;
        logic [EXT_Q_W-1:0] ext_qperi;
        logic               en_pm;
        pm_sign_e           pm_sign;
    } pi_cfg_t;

endpackage

//--- pi_ctrl.f
hdl/pi_pkg.sv
hdl/pi_cmd_fifo.sv
hdl/pi_cfg_regs.sv
hdl/pi_code_sequencer.sv
hdl/pi_local_encoder.sv
hdl/phase_monitor.sv
hdl/pi_ctrl_top.sv
testbench/tb_pi_ctrl.sv

//--- testbench/pi_ctrl_cases.txt
# op(dec: 0 set, 1 up, 2 down, 3 cfg) arg(hex) arb_ones(dec) exp_code(hex) exp_pm(hex)
# cfg arg bits: [11] en_ext_qperi, [10:3] ext_qperi, [2] en_pm, [1:0] pm_sign
0 0025 2 025 00000
3 0005 2 025 00000
1 0000 2 026 00001
0 0200 2 07f 0005a
1 0000 2 000 fffdb
2 0000 2 07f 0005a
2 0000 2 07e 00059
0 0010 2 010 fffeb
3 0006 2 010 fffeb
0 0130 5 130 ffecb
1 0000 5 131 ffeca
0 013f 5 13f ffebc
2 0000 5 13e ffebd
1 0000 5 13f ffebc
1 0000 5 000 ffffb
2 0000 5 13f ffebc
3 0818 5 13f ffebc
0 01ff 5 0bf ffebc
1 0000 5 000 ffebc
3 084d 5 000 ffebc
0 01f5 5 1f5 000b1
3 0005 0 1f5 000b1
0 0000 0 000 ffebc
2 0000 0 03f ffefb
0 0fff 32 1ff 000bb

//--- testbench/tb_pi_ctrl.sv
`timescale 1ns/1ps

module tb_pi_ctrl;

    localparam int NUNIT = 32;
    localparam int NBLENDER = 4;
    localparam int CMD_DEPTH = 4;
    localparam int SEL_W = $clog2(NUNIT);
    localparam int CODE_W = SEL_W + NBLENDER;
    localparam int QW = $clog2(NUNIT + 1);
    localparam int NTHM = 2**NBLENDER;
    localparam int SNAP_W = QW + 3 * SEL_W + NUNIT + NTHM + pi_pkg::PM_W;

    typedef struct packed {
        pi_pkg::pi_op_e               op;
        logic [pi_pkg::CMD_ARG_W-1:0] arg;
        logic [QW-1:0]                ones;
        logic [CODE_W-1:0]            code;
        logic [pi_pkg::PM_W-1:0]      pm;
    } case_t;

    typedef struct packed {
        logic [CODE_W-1:0]       code;
        logic [QW-1:0]           q;
        logic [pi_pkg::PM_W-1:0] pm;
    } expect_t;

    logic                     bld_out;
    logic                     rstb;
    logic                     freeze;
    logic                     cmd_valid;
    pi_pkg::pi_cmd_t          cmd;
    logic [NUNIT-1:0]         arb_out;
    logic                     credit;
    logic [QW-1:0]            qperi;
    logic [SEL_W-1:0]         max_sel_mux;
    logic [SEL_W-1:0]         sel_lead;
    logic [SEL_W-1:0]         sel_lag;
    logic [NUNIT-1:0]         en_mixer;
    logic [NTHM-1:0]          thm_sel_bld;
    logic [pi_pkg::PM_W-1:0]  pm_out;
    logic [SNAP_W-1:0]        out_now;
    logic [SNAP_W-1:0]        snap;

    case_t             cases[$];
    expect_t           exp_q[$];
    expect_t           rst_view;
    int                credits;
    int                cycles;
    int                limit;
    int                frz_left;
    int                frz_edges;
    int                cur_ones;
    logic              pend;
    logic              saw_stall;
    pi_pkg::pi_op_e    last_op;
    // Reference model state.
    logic [CODE_W-1:0]       ref_code;
    logic [pi_pkg::PM_W-1:0] ref_pm;
    pi_pkg::pi_cfg_t         ref_cfg;

    pi_ctrl_top #(
        .NUNIT(NUNIT),
        .NBLENDER(NBLENDER),
        .CMD_DEPTH(CMD_DEPTH)
    ) u_pi_ctrl_top (
        .bld_out(bld_out),
        .rstb(rstb),
        .freeze(freeze),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .arb_out(arb_out),
        .credit(credit),
        .qperi(qperi),
        .max_sel_mux(max_sel_mux),
        .sel_lead(sel_lead),
        .sel_lag(sel_lag),
        .en_mixer(en_mixer),
        .thm_sel_bld(thm_sel_bld),
        .pm_out(pm_out)
    );

    assign out_now = {qperi, max_sel_mux, sel_lead, sel_lag, en_mixer, thm_sel_bld, pm_out};

    initial begin
        bld_out = 1'b0;
        forever #20 bld_out = ~bld_out;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped.");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, got);
        abort_run("Output mismatch.");
    endtask

    function automatic int quarter(input pi_pkg::pi_cfg_t c, input int ones);
        return c.en_ext_qperi ? int'(c.ext_qperi) : ones;
    endfunction

    // Delay units in use, P.
    function automatic int units(input int q);
        int qe;
        qe = (q == 0) ? 1 : q;
        return (4 * qe > NUNIT) ? NUNIT : 4 * qe;
    endfunction

    function automatic logic [NUNIT-1:0] spread_ones(input int n, input int rot);
        logic [NUNIT-1:0] t;
        t = '0;
        for (int i = 0; i < n; i++) begin
            t[i] = 1'b1;
        end
        return (t << rot) | (t >> (NUNIT - rot));  // Rotation keeps the count.
    endfunction

    task automatic check_outputs(input expect_t e);
        int p;
        int coarse;
        int fine;
        int lag;
        logic [NUNIT-1:0] mix;
        logic [NTHM-1:0]  thm;
        p = units(int'(e.q));
        coarse = int'(e.code) >> NBLENDER;
        fine = int'(e.code) % NTHM;
        lag = (coarse >= p - 1) ? 0 : coarse + 1;  // Lag wraps past max_sel_mux.
        mix = '0;
        mix[coarse] = 1'b1;
        mix[lag] = 1'b1;
        thm = '0;
        for (int i = 0; i < fine; i++) begin
            thm[i] = 1'b1;
        end
        assert (qperi == e.q) else report_mismatch("qperi", e.q, qperi);
        assert (max_sel_mux == SEL_W'(p - 1))
            else report_mismatch("max_sel_mux", p - 1, max_sel_mux);
        assert (sel_lead == SEL_W'(coarse)) else report_mismatch("sel_lead", coarse, sel_lead);
        assert (sel_lag == SEL_W'(lag)) else report_mismatch("sel_lag", lag, sel_lag);
        assert (en_mixer == mix) else report_mismatch("en_mixer", mix, en_mixer);
        assert (thm_sel_bld == thm) else report_mismatch("thm_sel_bld", thm, thm_sel_bld);
        assert (pm_out == e.pm) else report_mismatch("pm_out", e.pm, pm_out);
    endtask

    // One falling edge of monitoring, checks and default drive.
    task automatic tick();
        @(negedge bld_out);
        cycles++;
        assert (cycles < limit)
            else abort_run($sformatf("Timeout, the run hung after %0d cycles.", cycles));
        frz_edges = freeze ? frz_edges + 1 : 0;
        if (frz_edges >= 1) begin
            assert (!credit) else abort_run("A credit came back while freeze was held.");
        end
        if (frz_edges >= 2) begin
            assert (out_now == snap) else abort_run("Outputs moved while freeze was held.");
        end
        if (pend) begin
            assert (exp_q.size() > 0) else abort_run("A credit came back for no command.");
            check_outputs(exp_q.pop_front());
        end
        pend = credit;
        if (credit) begin
            credits++;
            assert (credits <= CMD_DEPTH) else abort_run("More credits came back than sent.");
        end
        snap = out_now;
        if (frz_left > 0) begin
            frz_left--;
        end
        freeze = (frz_left > 0);
        cmd_valid = 1'b0;
    endtask

    task automatic model_command(input case_t c);
        int last;
        int next;
        int delta;
        last = units(quarter(ref_cfg, cur_ones)) * NTHM - 1;
        next = int'(ref_code);
        case (c.op)
            pi_pkg::OP_SET_CODE:  next = (int'(c.arg) > last) ? last : int'(c.arg);
            pi_pkg::OP_STEP_UP:   next = (int'(ref_code) >= last) ? 0 : int'(ref_code) + 1;
            pi_pkg::OP_STEP_DOWN: next = (ref_code == '0) ? last : int'(ref_code) - 1;
            default:              ref_cfg = pi_pkg::pi_cfg_t'(c.arg[pi_pkg::CFG_W-1:0]);
        endcase
        delta = next - int'(ref_code);
        if (c.op != pi_pkg::OP_WR_CFG && ref_cfg.en_pm) begin
            if (ref_cfg.pm_sign == pi_pkg::PM_ADD) begin
                ref_pm = ref_pm + pi_pkg::PM_W'(delta);
            end else if (ref_cfg.pm_sign == pi_pkg::PM_SUB) begin
                ref_pm = ref_pm - pi_pkg::PM_W'(delta);
            end
        end
        ref_code = CODE_W'(next);
        assert (ref_code == c.code && ref_pm == c.pm)
            else abort_run($sformatf("Case file expects code 0x%0h pm 0x%0h, model 0x%0h 0x%0h.",
                                     c.code, c.pm, ref_code, ref_pm));
        exp_q.push_back({ref_code, QW'(quarter(ref_cfg, cur_ones)), ref_pm});
    endtask

    task automatic send_command(input case_t c);
        while (credits == 0) begin
            if (freeze) begin
                saw_stall = 1'b1;
            end
            tick();
        end
        cmd_valid = 1'b1;
        cmd.op = c.op;
        cmd.arg = c.arg;
        credits--;
        model_command(c);
        tick();
    endtask

    task automatic drain();
        while (credits != CMD_DEPTH || pend || exp_q.size() != 0) begin
            tick();
        end
    endtask

    task automatic load_cases();
        int fd;
        int op_i;
        int ones_i;
        logic [31:0] arg_v;
        logic [31:0] code_v;
        logic [31:0] pm_v;
        string line;
        case_t c;
        fd = $fopen("testbench/pi_ctrl_cases.txt", "r");
        assert (fd != 0) else abort_run("Cannot open the case file.");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%d %h %d %h %h", op_i, arg_v, ones_i, code_v, pm_v) == 5) begin
                c.op = pi_pkg::pi_op_e'(op_i[1:0]);
                c.arg = arg_v[pi_pkg::CMD_ARG_W-1:0];
                c.ones = QW'(ones_i);
                c.code = code_v[CODE_W-1:0];
                c.pm = pm_v[pi_pkg::PM_W-1:0];
                cases.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        rstb = 1'b0;
        freeze = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        arb_out = '0;
        credits = CMD_DEPTH;
        cycles = 0;
        limit = 1000;
        frz_left = 0;
        frz_edges = 0;
        cur_ones = 0;
        pend = 1'b0;
        saw_stall = 1'b0;
        last_op = pi_pkg::OP_SET_CODE;
        ref_code = '0;
        ref_pm = '0;
        ref_cfg = '0;
        rst_view = '0;
        snap = '0;
        void'($urandom(32'hea95_b777));
        load_cases();
        assert (cases.size() > 0) else abort_run("The case file holds no cases.");
        limit = cases.size() * 20 + 200;

        repeat (8) tick();
        rstb = 1'b1;
        repeat (2) tick();
        assert (!credit) else report_mismatch("credit", 0, credit);
        check_outputs(rst_view);  // Code 0, qperi 0, monitor cleared.

        foreach (cases[i]) begin
            if (int'(cases[i].ones) != cur_ones || last_op == pi_pkg::OP_WR_CFG) begin
                drain();  // Range settles before the next code command.
                cur_ones = int'(cases[i].ones);
                arb_out = spread_ones(cur_ones, int'($urandom % NUNIT));
                repeat (2) tick();
            end
            if (i % 8 == 4) begin
                frz_left = 8 + int'($urandom % 6);
                freeze = 1'b1;
            end else if (!freeze) begin
                repeat ($urandom % 3) tick();
            end
            send_command(cases[i]);
            last_op = cases[i].op;
        end
        drain();
        assert (saw_stall) else abort_run("The driver never stalled at zero credits.");
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
